//--- compile.f
design/rv_pkg.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_wb_master.sv
design/rv_control.sv
design/rv_core_top.sv
testbench/tb_wb_mem.sv
testbench/tb_rv_core.sv

//--- design/rv_alu.sv
`timescale 1ns/1ns

module rv_alu import rv_pkg::*; (
    input  logic            i_clk,
    input  logic            i_exec,
    input  decoded_t        i_dec,
    input  logic [XLEN-1:0] i_rs1,
    input  logic [XLEN-1:0] i_rs2,
    output logic [XLEN-1:0] o_result,
    output logic            o_eq
);

    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] result;

    // Loads and stores take the immediate as address offset.
    always_comb begin
        case (i_dec.cls)
            CLS_LUI, CLS_ALU_IMM, CLS_LOAD, CLS_STORE: op_b = i_dec.imm;
            default: op_b = i_rs2;
        endcase
    end

    always_comb begin
        case (i_dec.op)
            ALU_ADD:  result = i_rs1 + op_b;
            ALU_SUB:  result = i_rs1 - op_b;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(i_rs1) < $signed(op_b)};
            ALU_XOR:  result = i_rs1 ^ op_b;
            ALU_OR:   result = i_rs1 | op_b;
            ALU_AND:  result = i_rs1 & op_b;
            ALU_PASS: result = op_b;
            default:  result = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_exec) begin
            o_result <= result;
            o_eq     <= (i_rs1 == i_rs2);
        end
    end

endmodule

//--- design/rv_control.sv
`timescale 1ns/1ns

module rv_control import rv_pkg::*; (
    input  logic            i_clk,
    input  logic            i_rst,
    input  decoded_t        i_dec,
    input  logic [XLEN-1:0] i_alu_result,
    input  logic            i_alu_eq,
    input  logic [XLEN-1:0] i_rs2,
    input  logic            i_bus_done,
    input  logic [XLEN-1:0] i_bus_rdata,
    output logic            o_bus_req,
    output bus_req_t        o_bus_req_data,
    output logic            o_dec_load,
    output logic            o_alu_exec,
    output logic            o_reg_we,
    output logic [XLEN-1:0] o_reg_wdata
);

    typedef enum logic [2:0] {
        S_FETCH_REQ,
        S_FETCH_WAIT,
        S_DECODE,
        S_OPERAND,
        S_EXECUTE,
        S_MEM_REQ,
        S_MEM_WAIT,
        S_WRITEBACK
    } step_t;

    step_t           step;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] branch_target;
    logic            is_mem;
    logic            taken;

    assign is_mem        = (i_dec.cls == CLS_LOAD) || (i_dec.cls == CLS_STORE);
    assign branch_target = pc + i_dec.imm;
    assign taken         = (i_dec.cls == CLS_BEQ && i_alu_eq) ||
                           (i_dec.cls == CLS_BNE && !i_alu_eq);
    assign next_pc       = taken ? branch_target : pc + 32'd4;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            step <= S_FETCH_REQ;
            pc   <= PC_RESET;
        end else begin
            case (step)
                S_FETCH_REQ:  step <= S_FETCH_WAIT;
                S_FETCH_WAIT: begin
                    if (i_bus_done) begin
                        step <= S_DECODE;
                    end
                end
                S_DECODE:     step <= S_OPERAND;
                S_OPERAND:    step <= S_EXECUTE;
                S_EXECUTE:    step <= is_mem ? S_MEM_REQ : S_WRITEBACK;
                S_MEM_REQ:    step <= S_MEM_WAIT;
                S_MEM_WAIT: begin
                    if (i_bus_done) begin
                        step <= S_WRITEBACK;
                    end
                end
                S_WRITEBACK: begin
                    pc   <= next_pc;
                    step <= S_FETCH_REQ;
                end
                default: step <= S_FETCH_REQ;
            endcase
        end
    end

    // Request states last one cycle each, so the request is a pulse.
    assign o_bus_req = (step == S_FETCH_REQ) || (step == S_MEM_REQ);

    always_comb begin
        o_bus_req_data.we   = (step == S_MEM_REQ) && (i_dec.cls == CLS_STORE);
        o_bus_req_data.addr = (step == S_MEM_REQ) ? i_alu_result : pc;
        o_bus_req_data.data = i_rs2;
    end

    assign o_dec_load = (step == S_FETCH_WAIT) && i_bus_done;
    assign o_alu_exec = (step == S_EXECUTE);

    always_comb begin
        case (i_dec.cls)
            CLS_LUI, CLS_ALU_IMM, CLS_ALU_REG, CLS_LOAD: o_reg_we = (step == S_WRITEBACK);
            default: o_reg_we = 1'b0;
        endcase
    end

    assign o_reg_wdata = (i_dec.cls == CLS_LOAD) ? i_bus_rdata : i_alu_result;

    a_req_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
        o_bus_req |=> !o_bus_req);

endmodule

//--- design/rv_core_top.sv
`timescale 1ns/1ns

module rv_core_top import rv_pkg::*; (
    input  logic            i_clk,
    input  logic            i_rst,
    output logic            o_cyc,
    output logic            o_stb,
    output logic            o_we,
    output logic [XLEN-1:0] o_addr,
    output logic [XLEN-1:0] o_dat,
    input  logic [XLEN-1:0] i_dat,
    input  logic            i_stall,
    input  logic            i_ack
);

    decoded_t        dec;
    logic            dec_load;
    logic            alu_exec;
    logic            reg_we;
    logic [XLEN-1:0] reg_wdata;
    logic [XLEN-1:0] rdata1;
    logic [XLEN-1:0] rdata2;
    logic [XLEN-1:0] alu_result;
    logic            alu_eq;
    logic            bus_req;
    bus_req_t        bus_req_data;
    logic            bus_done;
    logic [XLEN-1:0] bus_rdata;

    rv_decoder u_decoder (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_load  (dec_load),
        .i_instr (bus_rdata),
        .o_dec   (dec)
    );

    rv_regfile u_regfile (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_we     (reg_we),
        .i_waddr  (dec.rd),
        .i_raddr1 (dec.rs1),
        .i_raddr2 (dec.rs2),
        .i_wdata  (reg_wdata),
        .o_rdata1 (rdata1),
        .o_rdata2 (rdata2)
    );

    rv_alu u_alu (
        .i_clk    (i_clk),
        .i_exec   (alu_exec),
        .i_dec    (dec),
        .i_rs1    (rdata1),
        .i_rs2    (rdata2),
        .o_result (alu_result),
        .o_eq     (alu_eq)
    );

    rv_wb_master u_wb_master (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_req      (bus_req),
        .i_req_data (bus_req_data),
        .o_done     (bus_done),
        .o_rdata    (bus_rdata),
        .o_cyc      (o_cyc),
        .o_stb      (o_stb),
        .o_we       (o_we),
        .o_addr     (o_addr),
        .o_dat      (o_dat),
        .i_dat      (i_dat),
        .i_stall    (i_stall),
        .i_ack      (i_ack)
    );

    rv_control u_control (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_dec          (dec),
        .i_alu_result   (alu_result),
        .i_alu_eq       (alu_eq),
        .i_rs2          (rdata2),
        .i_bus_done     (bus_done),
        .i_bus_rdata    (bus_rdata),
        .o_bus_req      (bus_req),
        .o_bus_req_data (bus_req_data),
        .o_dec_load     (dec_load),
        .o_alu_exec     (alu_exec),
        .o_reg_we       (reg_we),
        .o_reg_wdata    (reg_wdata)
    );

endmodule

//--- design/rv_decoder.sv
`timescale 1ns/1ns

module rv_decoder import rv_pkg::*; (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_load,
    input  logic [XLEN-1:0] i_instr,
    output decoded_t        o_dec
);

    logic [XLEN-1:0] instr;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;

    // Cleared word has opcode zero, which decodes as a no-op.
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            instr <= '0;
        end else if (i_load) begin
            instr <= i_instr;
        end
    end

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        o_dec.cls = CLS_NONE;
        o_dec.op  = ALU_ADD;
        o_dec.rs1 = instr[19:15];
        o_dec.rs2 = instr[24:20];
        o_dec.rd  = instr[11:7];
        o_dec.imm = imm_i;
        case (opcode)
            OPC_LUI: begin
                o_dec.cls = CLS_LUI;
                o_dec.op  = ALU_PASS;
                o_dec.imm = imm_u;
            end
            OPC_OP_IMM: begin
                o_dec.cls = CLS_ALU_IMM;
                case (funct3)
                    F3_ADD_SUB: o_dec.op = ALU_ADD;
                    F3_SLT:     o_dec.op = ALU_SLT;
                    F3_XOR:     o_dec.op = ALU_XOR;
                    F3_OR:      o_dec.op = ALU_OR;
                    F3_AND:     o_dec.op = ALU_AND;
                    default:    o_dec.cls = CLS_NONE;
                endcase
            end
            OPC_OP: begin
                // Only SUB may carry a nonzero funct7.
                if (funct7 == 7'b0 || (funct7 == F7_SUB && funct3 == F3_ADD_SUB)) begin
                    o_dec.cls = CLS_ALU_REG;
                    case (funct3)
                        F3_ADD_SUB: o_dec.op = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                        F3_SLT:     o_dec.op = ALU_SLT;
                        F3_XOR:     o_dec.op = ALU_XOR;
                        F3_OR:      o_dec.op = ALU_OR;
                        F3_AND:     o_dec.op = ALU_AND;
                        default:    o_dec.cls = CLS_NONE;
                    endcase
                end
            end
            OPC_BRANCH: begin
                o_dec.imm = imm_b;
                if (funct3 == F3_BEQ) begin
                    o_dec.cls = CLS_BEQ;
                end else if (funct3 == F3_BNE) begin
                    o_dec.cls = CLS_BNE;
                end
            end
            OPC_LOAD: begin
                if (funct3 == F3_LW_SW) begin
                    o_dec.cls = CLS_LOAD;
                end
            end
            OPC_STORE: begin
                o_dec.imm = imm_s;
                if (funct3 == F3_LW_SW) begin
                    o_dec.cls = CLS_STORE;
                end
            end
            default: o_dec.cls = CLS_NONE;
        endcase
    end

endmodule

//--- design/rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    localparam logic [XLEN-1:0] PC_RESET = 32'h0000_0000;

    // RV32I major opcodes.
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_LW_SW   = 3'b010;

    localparam logic [6:0] F7_SUB = 7'b0100000;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_PASS
    } alu_op_t;

    typedef enum logic [2:0] {
        CLS_NONE,
        CLS_LUI,
        CLS_ALU_IMM,
        CLS_ALU_REG,
        CLS_BEQ,
        CLS_BNE,
        CLS_LOAD,
        CLS_STORE
    } instr_class_t;

    typedef struct packed {
        instr_class_t          cls;
        alu_op_t               op;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       imm;
    } decoded_t;

    typedef struct packed {
        logic            we;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
    } bus_req_t;

endpackage

//--- design/rv_regfile.sv
`timescale 1ns/1ns

module rv_regfile import rv_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_we,
    input  logic [REG_ADDR_W-1:0] i_waddr,
    input  logic [REG_ADDR_W-1:0] i_raddr1,
    input  logic [REG_ADDR_W-1:0] i_raddr2,
    input  logic [XLEN-1:0]       i_wdata,
    output logic [XLEN-1:0]       o_rdata1,
    output logic [XLEN-1:0]       o_rdata2
);

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_waddr != '0) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    assign o_rdata1 = regs[i_raddr1];
    assign o_rdata2 = regs[i_raddr2];

    // x0 must survive every write since reset.
    a_x0_zero: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_raddr1 == '0) |-> (o_rdata1 == '0));

endmodule

//--- design/rv_wb_master.sv
`timescale 1ns/1ns

module rv_wb_master import rv_pkg::*; (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_req,
    input  bus_req_t        i_req_data,
    output logic            o_done,
    output logic [XLEN-1:0] o_rdata,
    output logic            o_cyc,
    output logic            o_stb,
    output logic            o_we,
    output logic [XLEN-1:0] o_addr,
    output logic [XLEN-1:0] o_dat,
    input  logic [XLEN-1:0] i_dat,
    input  logic            i_stall,
    input  logic            i_ack
);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_cyc  <= 1'b0;
            o_stb  <= 1'b0;
            o_we   <= 1'b0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_req) begin
                o_cyc <= 1'b1;
                o_stb <= 1'b1;
                o_we  <= i_req_data.we;
            end else begin
                // Strobe is accepted on the first cycle without stall.
                if (o_stb && !i_stall) begin
                    o_stb <= 1'b0;
                end
                if (o_cyc && i_ack) begin
                    o_cyc  <= 1'b0;
                    o_stb  <= 1'b0;
                    o_we   <= 1'b0;
                    o_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_req) begin
            o_addr <= i_req_data.addr;
            o_dat  <= i_req_data.data;
        end
        if (o_cyc && i_ack) begin
            o_rdata <= i_dat;
        end
    end

    a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (i_rst)
        o_stb |-> o_cyc);

    // One outstanding transaction.
    a_req_idle: assert property (@(posedge i_clk) disable iff (i_rst)
        i_req |-> !o_cyc);

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_rv_core -f compile.f -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "Everything OK" &&
echo "Simulation passed" ||
{ echo "Simulation did not pass"; exit 1; }

//--- testbench/tb_rv_core.sv
`timescale 1ns/1ns

module tb_rv_core import rv_pkg::*; ();

    localparam int          NSLOT     = 19;
    localparam logic [31:0] RES_BASE  = 32'h300;
    localparam logic [31:0] DATA_BASE = 32'h200;
    localparam int          LIMIT     = 20000;

    logic        i_clk = 1'b0;
    logic        i_rst = 1'b1;
    logic        o_cyc;
    logic        o_stb;
    logic        o_we;
    logic [31:0] o_addr;
    logic [31:0] o_dat;
    logic [31:0] i_dat;
    logic        i_stall;
    logic        i_ack;

    logic [31:0] exp_val [NSLOT];
    logic        exp_valid [NSLOT];
    string       test_name [NSLOT] = '{"add", "sub", "slt", "xor", "or", "and",
        "addi", "slti", "xori", "ori", "andi", "lui", "beq_taken", "bne_taken",
        "beq_not_taken", "bne_not_taken", "sw_direct", "lw_sw_round_trip", "add_x0"};
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    logic [31:0] pc_emit;
    logic [31:0] end_pc;
    logic [31:0] rnd = 32'hb225;

    always #4 i_clk = ~i_clk;

    rv_core_top DUT (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .o_cyc   (o_cyc),
        .o_stb   (o_stb),
        .o_we    (o_we),
        .o_addr  (o_addr),
        .o_dat   (o_dat),
        .i_dat   (i_dat),
        .i_stall (i_stall),
        .i_ack   (i_ack)
    );

    tb_wb_mem MEM (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_cyc   (o_cyc),
        .i_stb   (o_stb),
        .i_we    (o_we),
        .i_addr  (o_addr),
        .i_dat   (o_dat),
        .o_dat   (i_dat),
        .o_stall (i_stall),
        .o_ack   (i_ack)
    );

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return addr ^ 32'hc3c3_0000 ^ {addr[15:0], 16'h0};
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, F3_LW_SW, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic store_ok(input logic [31:0] addr, input logic [31:0] dat);
        int slot;
        if (addr < RES_BASE || addr >= RES_BASE + 32'(NSLOT * 4)) begin
            return 1'b0;
        end
        slot = int'((addr - RES_BASE) >> 2);
        return exp_valid[slot] && exp_val[slot] == dat;
    endfunction

    task automatic report_bad_store(input logic [31:0] addr, input logic [31:0] dat);
        int slot;
        errors++;
        slot = int'((addr - RES_BASE) >> 2);
        if (addr >= RES_BASE && slot < NSLOT && exp_valid[slot]) begin
            $display("Fail %s: expected %h, actual %h", test_name[slot], exp_val[slot], dat);
        end else begin
            $display("A store went to address %h, where no store is allowed", addr);
        end
    endtask

    task automatic put(input logic [31:0] word);
        MEM.mem[pc_emit[11:2]] = word;
        pc_emit = pc_emit + 32'd4;
    endtask

    // Every accepted store must match the rule for its result address.
    a_store: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_cyc && o_stb && !i_stall && o_we) |-> store_ok(o_addr, o_dat))
        else report_bad_store(o_addr, o_dat);

    a_stb_cyc: assert property (@(posedge i_clk) disable iff (i_rst)
        o_stb |-> o_cyc)
        else begin
            errors++;
            $display("Strobe was high while cycle was low");
        end

    a_addr_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_stb && i_stall) |=> (o_stb && $stable(o_addr)))
        else begin
            errors++;
            $display("Address or strobe changed while the bus was stalled");
        end

    task automatic load_memory();
        logic [31:0] d0;
        logic [31:0] d1;
        for (int i = 0; i < 1024; i++) begin
            MEM.mem[i] = fill_word(32'(i) << 2);
        end
        rnd = next_rand(rnd);
        d0 = rnd;
        rnd = next_rand(rnd);
        d1 = rnd;
        // Branch tests need unequal words.
        if (d1 == d0) begin
            d1 = d1 ^ 32'h1;
        end
        MEM.mem[DATA_BASE[11:2]]         = d0;
        MEM.mem[DATA_BASE[11:2] + 10'd1] = d1;

        exp_val[0]  = d0 + d1;
        exp_val[1]  = d0 - d1;
        exp_val[2]  = ($signed(d0) < $signed(d1)) ? 32'd1 : 32'd0;
        exp_val[3]  = d0 ^ d1;
        exp_val[4]  = d0 | d1;
        exp_val[5]  = d0 & d1;
        exp_val[6]  = d0 + sext12(12'hb2e);
        exp_val[7]  = ($signed(d0) < $signed(sext12(12'hffb))) ? 32'd1 : 32'd0;
        exp_val[8]  = d0 ^ sext12(12'h5a5);
        exp_val[9]  = d0 | sext12(12'h800);
        exp_val[10] = d0 & sext12(12'h0f0);
        exp_val[11] = 32'habcde << 12;
        exp_val[12] = fill_word(RES_BASE + 32'd48);
        exp_val[13] = fill_word(RES_BASE + 32'd52);
        exp_val[14] = 32'h77;
        exp_val[15] = 32'h77;
        exp_val[16] = d0;
        exp_val[17] = d0;
        exp_val[18] = 32'h0;
        for (int s = 0; s < NSLOT; s++) begin
            exp_valid[s] = (s != 12 && s != 13);
        end

        pc_emit = PC_RESET;
        put(enc_i(12'h200, 5'd0, F3_LW_SW, 5'd1, OPC_LOAD));
        put(enc_i(12'h204, 5'd0, F3_LW_SW, 5'd2, OPC_LOAD));
        put(enc_r(7'b0, 5'd2, 5'd1, F3_ADD_SUB, 5'd3));
        put(enc_s(12'h300, 5'd3, 5'd0));
        put(enc_r(F7_SUB, 5'd2, 5'd1, F3_ADD_SUB, 5'd3));
        put(enc_s(12'h304, 5'd3, 5'd0));
        put(enc_r(7'b0, 5'd2, 5'd1, F3_SLT, 5'd3));
        put(enc_s(12'h308, 5'd3, 5'd0));
        put(enc_r(7'b0, 5'd2, 5'd1, F3_XOR, 5'd3));
        put(enc_s(12'h30c, 5'd3, 5'd0));
        put(enc_r(7'b0, 5'd2, 5'd1, F3_OR, 5'd3));
        put(enc_s(12'h310, 5'd3, 5'd0));
        put(enc_r(7'b0, 5'd2, 5'd1, F3_AND, 5'd3));
        put(enc_s(12'h314, 5'd3, 5'd0));
        put(enc_i(12'hb2e, 5'd1, F3_ADD_SUB, 5'd3, OPC_OP_IMM));
        put(enc_s(12'h318, 5'd3, 5'd0));
        put(enc_i(12'hffb, 5'd1, F3_SLT, 5'd3, OPC_OP_IMM));
        put(enc_s(12'h31c, 5'd3, 5'd0));
        put(enc_i(12'h5a5, 5'd1, F3_XOR, 5'd3, OPC_OP_IMM));
        put(enc_s(12'h320, 5'd3, 5'd0));
        put(enc_i(12'h800, 5'd1, F3_OR, 5'd3, OPC_OP_IMM));
        put(enc_s(12'h324, 5'd3, 5'd0));
        put(enc_i(12'h0f0, 5'd1, F3_AND, 5'd3, OPC_OP_IMM));
        put(enc_s(12'h328, 5'd3, 5'd0));
        put({20'habcde, 5'd3, OPC_LUI});
        put(enc_s(12'h32c, 5'd3, 5'd0));
        // Marker in x4, then two taken and two not-taken branches.
        put(enc_i(12'h077, 5'd0, F3_ADD_SUB, 5'd4, OPC_OP_IMM));
        put(enc_b(13'd8, 5'd1, 5'd1, F3_BEQ));
        put(enc_s(12'h330, 5'd4, 5'd0));
        put(enc_b(13'd8, 5'd2, 5'd1, F3_BNE));
        put(enc_s(12'h334, 5'd4, 5'd0));
        put(enc_b(13'd8, 5'd2, 5'd1, F3_BEQ));
        put(enc_s(12'h338, 5'd4, 5'd0));
        put(enc_b(13'd8, 5'd1, 5'd1, F3_BNE));
        put(enc_s(12'h33c, 5'd4, 5'd0));
        put(enc_s(12'h340, 5'd1, 5'd0));
        put(enc_i(12'h340, 5'd0, F3_LW_SW, 5'd5, OPC_LOAD));
        put(enc_s(12'h344, 5'd5, 5'd0));
        put(enc_r(7'b0, 5'd2, 5'd1, F3_ADD_SUB, 5'd0));
        put(enc_s(12'h348, 5'd0, 5'd0));
        end_pc = pc_emit;
        put(enc_b(13'd0, 5'd0, 5'd0, F3_BEQ));
    endtask

    task automatic wait_first_fetch(output logic ok);
        int n;
        n = 0;
        while (!o_stb && n < LIMIT) begin
            @(negedge i_clk);
            n++;
        end
        ok = o_stb;
    endtask

    task automatic wait_program_end(output logic ok);
        int n;
        n = 0;
        while (!(o_stb && !o_we && o_addr == end_pc) && n < LIMIT) begin
            @(negedge i_clk);
            n++;
        end
        ok = (n < LIMIT);
    endtask

    task automatic check_results();
        logic [31:0] got;
        for (int s = 0; s < NSLOT; s++) begin
            got = MEM.mem[RES_BASE[11:2] + s[9:0]];
            tests_run++;
            assert (got == exp_val[s]) begin
                $display("Pass %s", test_name[s]);
            end else begin
                tests_failed++;
                $display("Fail %s: expected %h, actual %h", test_name[s], exp_val[s], got);
            end
        end
    endtask

    initial begin
        logic ok;
        load_memory();
        repeat (2) @(posedge i_clk);
        #1 i_rst = 1'b0;
        wait_first_fetch(ok);
        if (ok) begin
            tests_run++;
            assert (o_addr == PC_RESET && !o_we) begin
                $display("Pass first_fetch");
            end else begin
                tests_failed++;
                $display("Fail first_fetch: expected addr %h we 0, actual addr %h we %b",
                         PC_RESET, o_addr, o_we);
            end
            wait_program_end(ok);
            if (ok) begin
                check_results();
            end else begin
                tests_failed++;
                $display("Timed out waiting for the program to reach its final loop");
            end
        end else begin
            tests_failed++;
            $display("Timed out waiting for the first fetch after reset");
        end
        $display("Tests run %0d, failed %0d, assertion errors %0d",
                 tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- testbench/tb_wb_mem.sv
`timescale 1ns/1ns

module tb_wb_mem (
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic        i_cyc,
    input  logic        i_stb,
    input  logic        i_we,
    input  logic [31:0] i_addr,
    input  logic [31:0] i_dat,
    output logic [31:0] o_dat,
    output logic        o_stall,
    output logic        o_ack
);

    logic [31:0] mem [1024];
    logic [31:0] seed     = 32'hb225;
    logic        stall_r  = 1'b0;
    logic        ack_r    = 1'b0;
    logic [31:0] dat_r    = '0;
    logic        busy     = 1'b0;
    logic [1:0]  wait_cnt = '0;
    logic [31:0] addr_q   = '0;
    logic        nxt_stall;
    logic        nxt_ack;
    logic [31:0] nxt_dat;

    assign o_stall = stall_r;
    assign o_ack   = ack_r;
    assign o_dat   = dat_r;

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // One transaction at a time, ack after 1 to 4 cycles.
    always @(posedge i_clk) begin
        nxt_stall = 1'b0;
        nxt_ack   = 1'b0;
        nxt_dat   = dat_r;
        if (i_rst) begin
            busy = 1'b0;
        end else begin
            seed = next_rand(seed);
            if (ack_r) begin
                busy = 1'b0;
            end else if (busy) begin
                if (wait_cnt == 2'd0) begin
                    nxt_ack = 1'b1;
                    nxt_dat = mem[addr_q[11:2]];
                end else begin
                    wait_cnt = wait_cnt - 2'd1;
                end
            end
            if (i_cyc && i_stb && !stall_r && !busy) begin
                busy     = 1'b1;
                addr_q   = i_addr;
                wait_cnt = seed[21:20];
                if (i_we) begin
                    mem[i_addr[11:2]] = i_dat;
                end
            end
            nxt_stall = (seed[9:8] == 2'd0);
        end
        #1;
        stall_r = nxt_stall;
        ack_r   = nxt_ack;
        dat_r   = nxt_dat;
    end

endmodule
